// File: verilog.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/reg_read_if.sv
rtl/issue_ctrl.sv
rtl/reg_file.sv
rtl/forwarding.sv
rtl/alu_lane.sv
rtl/dual_issue_core.sv
bench/dual_issue_asserts.sv
bench/tb_dual_issue_core.sv

// File: Makefile
SIM  := obj_dir/Vtb_dual_issue_core
SRCS := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --assert -f verilog.f --top-module tb_dual_issue_core

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log; grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_dual_issue_core.sv
`timescale 1ns/1ns

module tb_dual_issue_core;

  localparam int n_random    = 300;
  localparam int n_directed  = 28;
  localparam int cycle_limit = 20 * (n_random + n_directed) + 100;
  localparam logic [31:0] nop_word = 32'h0000_0000;

  logic        clk;
  logic        rst;
  logic        issue_valid;
  logic [31:0] instr0;
  logic [31:0] instr1;
  logic        issue_ready;
  logic        wb0_en;
  logic [4:0]  wb0_addr;
  logic [31:0] wb0_data;
  logic        wb1_en;
  logic [4:0]  wb1_addr;
  logic [31:0] wb1_data;

  // Expected lane results per stage from issue to writeback
  logic [1:0]       cur_en;
  logic [1:0][4:0]  cur_addr;
  logic [1:0][31:0] cur_data;
  logic [1:0]       ex_en;
  logic [1:0][4:0]  ex_addr;
  logic [1:0][31:0] ex_data;
  logic [1:0]       wb_en_exp;
  logic [1:0][4:0]  wb_addr_exp;
  logic [1:0][31:0] wb_data_exp;
  logic             exp_ready;

  logic [31:0] model [32];  // Architectural registers
  logic [31:0] rng;
  logic [31:0] w0;
  logic [31:0] w1;
  int unsigned cycles = 0;
  string       test_name;

  dual_issue_core u_dut (
    .clk, .rst, .issue_valid, .instr0, .instr1, .issue_ready,
    .wb0_en, .wb0_addr, .wb0_data, .wb1_en, .wb1_addr, .wb1_data
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    ex_en       <= cur_en;
    ex_addr     <= cur_addr;
    ex_data     <= cur_data;
    wb_en_exp   <= ex_en;
    wb_addr_exp <= ex_addr;
    wb_data_exp <= ex_data;
  end

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
    abort_run();
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      abort_run();
    end else if (u_dut.u_asserts.fail_count != 0) begin
      $display("A protocol assertion inside the core failed");
      abort_run();
    end
  end

  // ====================
  // Checks
  // ====================
  a_ready: assert property (@(posedge clk) disable iff (rst) issue_ready == exp_ready)
    else report_mismatch("issue_ready", 32'($sampled(exp_ready)), 32'($sampled(issue_ready)));
  a_wb0_en: assert property (@(posedge clk) disable iff (rst) wb0_en == wb_en_exp[0])
    else report_mismatch("wb0_en", 32'($sampled(wb_en_exp[0])), 32'($sampled(wb0_en)));
  a_wb1_en: assert property (@(posedge clk) disable iff (rst) wb1_en == wb_en_exp[1])
    else report_mismatch("wb1_en", 32'($sampled(wb_en_exp[1])), 32'($sampled(wb1_en)));
  a_wb0_addr: assert property (@(posedge clk) disable iff (rst)
    wb_en_exp[0] |-> wb0_addr == wb_addr_exp[0])
    else report_mismatch("wb0_addr", 32'($sampled(wb_addr_exp[0])), 32'($sampled(wb0_addr)));
  a_wb1_addr: assert property (@(posedge clk) disable iff (rst)
    wb_en_exp[1] |-> wb1_addr == wb_addr_exp[1])
    else report_mismatch("wb1_addr", 32'($sampled(wb_addr_exp[1])), 32'($sampled(wb1_addr)));
  a_wb0_data: assert property (@(posedge clk) disable iff (rst)
    wb_en_exp[0] |-> wb0_data == wb_data_exp[0])
    else report_mismatch("wb0_data", $sampled(wb_data_exp[0]), $sampled(wb0_data));
  a_wb1_data: assert property (@(posedge clk) disable iff (rst)
    wb_en_exp[1] |-> wb1_data == wb_data_exp[1])
    else report_mismatch("wb1_data", $sampled(wb_data_exp[1]), $sampled(wb1_data));

  // ====================
  // Encoding and reference model
  // ====================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [2:0] funct3_of(input logic [2:0] op);
    case (op)
      isa_pkg::alu_slt: return isa_pkg::f3_slt;
      isa_pkg::alu_xor: return isa_pkg::f3_xor;
      isa_pkg::alu_or:  return isa_pkg::f3_or;
      isa_pkg::alu_and: return isa_pkg::f3_and;
      default:          return isa_pkg::f3_add_sub;
    endcase
  endfunction

  function automatic logic [31:0] rr(input logic [2:0] op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
    isa_pkg::instr_u w;
    w.r.funct7 = (op == isa_pkg::alu_sub) ? isa_pkg::f7_alt : isa_pkg::f7_base;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3_of(op);
    w.r.rd     = rd;
    w.r.opcode = isa_pkg::opc_op;
    return w;
  endfunction

  function automatic logic [31:0] ri(input logic [2:0] op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
    isa_pkg::instr_u w;
    w.i.imm12  = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = funct3_of(op);
    w.i.rd     = rd;
    w.i.opcode = isa_pkg::opc_op_imm;
    return w;
  endfunction

  function automatic logic is_alu_op(input isa_pkg::instr_u w);
    logic f3_ok;
    f3_ok = w.r.funct3 inside {isa_pkg::f3_add_sub, isa_pkg::f3_slt, isa_pkg::f3_xor,
                               isa_pkg::f3_or, isa_pkg::f3_and};
    if (w.r.opcode == isa_pkg::opc_op_imm) return f3_ok;
    if (w.r.opcode != isa_pkg::opc_op) return 1'b0;
    return f3_ok && (w.r.funct7 == isa_pkg::f7_base ||
                     (w.r.funct7 == isa_pkg::f7_alt && w.r.funct3 == isa_pkg::f3_add_sub));
  endfunction

  function automatic logic writes_rd(input isa_pkg::instr_u w);
    return is_alu_op(w) && w.r.rd != 5'd0;
  endfunction

  function automatic logic reads_rs2(input isa_pkg::instr_u w);
    return is_alu_op(w) && w.r.opcode == isa_pkg::opc_op;
  endfunction

  function automatic logic [31:0] alu_ref(input isa_pkg::instr_u w, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] rhs;
    logic        is_imm;
    is_imm = (w.r.opcode == isa_pkg::opc_op_imm);
    rhs    = is_imm ? {{20{w.i.imm12[11]}}, w.i.imm12} : b;
    case (w.r.funct3)
      isa_pkg::f3_add_sub: return (!is_imm && w.r.funct7[5]) ? a - rhs : a + rhs;
      isa_pkg::f3_slt:     return {31'd0, $signed(a) < $signed(rhs)};
      isa_pkg::f3_xor:     return a ^ rhs;
      isa_pkg::f3_or:      return a | rhs;
      default:             return a & rhs;
    endcase
  endfunction

  // Only x0..x7 so that dependences are frequent
  function automatic logic [31:0] random_instr(input logic [31:0] r);
    logic [2:0] op;
    op = (r[6:4] > isa_pkg::alu_slt) ? isa_pkg::alu_add : r[6:4];
    if (r[2:0] == 3'd0) return {r[31:7], 7'b0000011};  // Load opcode is a no-op here
    if (r[3]) return rr(op, {2'b00, r[9:7]}, {2'b00, r[12:10]}, {2'b00, r[15:13]});
    if (op == isa_pkg::alu_sub) op = isa_pkg::alu_add;
    return ri(op, {2'b00, r[9:7]}, {2'b00, r[12:10]}, r[27:16]);
  endfunction

  // ====================
  // Stimulus
  // ====================
  task automatic issue_lane(input logic lane, input isa_pkg::instr_u w);
    logic [31:0] result;
    result = alu_ref(w, model[w.r.rs1], model[w.r.rs2]);
    cur_en[lane]   <= writes_rd(w);
    cur_addr[lane] <= w.r.rd;
    cur_data[lane] <= result;
    if (writes_rd(w)) model[w.r.rd] = result;  // Program order with lane 0 first
  endtask

  task automatic send_bundle(input logic [31:0] i0, input logic [31:0] i1);
    isa_pkg::instr_u u0;
    isa_pkg::instr_u u1;
    logic            split;
    u0    = i0;
    u1    = i1;
    split = writes_rd(u0) && ((is_alu_op(u1) && u1.r.rs1 == u0.r.rd) ||
                              (reads_rs2(u1) && u1.r.rs2 == u0.r.rd));
    issue_valid <= 1'b1;
    instr0      <= i0;
    instr1      <= i1;
    exp_ready   <= !split;
    cur_en      <= 2'b00;
    issue_lane(1'b0, u0);
    if (!split) issue_lane(1'b1, u1);
    @(posedge clk);
    if (!issue_ready) begin  // Bundle held while lane 1 goes alone
      exp_ready <= 1'b1;
      cur_en    <= 2'b00;
      issue_lane(1'b1, u1);
      @(posedge clk);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      issue_valid <= 1'b0;
      exp_ready   <= 1'b1;
      cur_en      <= 2'b00;
      @(posedge clk);
    end
  endtask

  initial begin
    rst         = 1'b1;
    issue_valid = 1'b0;
    instr0      = '0;
    instr1      = '0;
    cur_en      = '0;
    cur_addr    = '0;
    cur_data    = '0;
    exp_ready   = 1'b1;
    rng         = 32'd75640;
    test_name   = "reset";
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    test_name = "independent";
    send_bundle(ri(isa_pkg::alu_add, 5'd1, 5'd0, 12'd5), ri(isa_pkg::alu_add, 5'd2, 5'd0, 12'hffd));
    send_bundle(ri(isa_pkg::alu_add, 5'd3, 5'd0, 12'h07f),
                ri(isa_pkg::alu_add, 5'd4, 5'd0, 12'hf9c));
    send_bundle(rr(isa_pkg::alu_add, 5'd5, 5'd1, 5'd2), rr(isa_pkg::alu_sub, 5'd6, 5'd3, 5'd4));
    send_bundle(rr(isa_pkg::alu_and, 5'd7, 5'd3, 5'd4), rr(isa_pkg::alu_or, 5'd8, 5'd1, 5'd4));
    send_bundle(rr(isa_pkg::alu_xor, 5'd9, 5'd2, 5'd3), rr(isa_pkg::alu_slt, 5'd10, 5'd4, 5'd1));
    send_bundle(ri(isa_pkg::alu_and, 5'd11, 5'd3, 12'h0f0),
                ri(isa_pkg::alu_or, 5'd12, 5'd4, 12'h800));
    send_bundle(ri(isa_pkg::alu_xor, 5'd13, 5'd2, 12'h555),
                ri(isa_pkg::alu_slt, 5'd14, 5'd4, 12'hffe));

    test_name = "fwd_execute";
    send_bundle(ri(isa_pkg::alu_add, 5'd16, 5'd0, 12'd11),
                ri(isa_pkg::alu_add, 5'd17, 5'd0, 12'd22));
    send_bundle(rr(isa_pkg::alu_add, 5'd18, 5'd16, 5'd17),
                rr(isa_pkg::alu_sub, 5'd19, 5'd17, 5'd16));
    send_bundle(ri(isa_pkg::alu_add, 5'd20, 5'd0, 12'd1), ri(isa_pkg::alu_add, 5'd20, 5'd0, 12'd2));
    send_bundle(rr(isa_pkg::alu_or, 5'd21, 5'd20, 5'd0),
                rr(isa_pkg::alu_add, 5'd22, 5'd20, 5'd20));

    test_name = "fwd_memory";
    send_bundle(ri(isa_pkg::alu_add, 5'd23, 5'd0, 12'd33),
                ri(isa_pkg::alu_xor, 5'd24, 5'd0, 12'h0c3));
    send_bundle(nop_word, nop_word);
    send_bundle(rr(isa_pkg::alu_add, 5'd25, 5'd23, 5'd24),
                rr(isa_pkg::alu_slt, 5'd26, 5'd24, 5'd23));

    test_name = "regfile_read";
    send_bundle(ri(isa_pkg::alu_add, 5'd27, 5'd0, 12'h123),
                ri(isa_pkg::alu_add, 5'd28, 5'd0, 12'h456));
    repeat (3) send_bundle(nop_word, nop_word);
    send_bundle(rr(isa_pkg::alu_xor, 5'd29, 5'd27, 5'd28),
                rr(isa_pkg::alu_sub, 5'd30, 5'd28, 5'd27));

    test_name = "split";
    send_bundle(ri(isa_pkg::alu_add, 5'd1, 5'd0, 12'd7), rr(isa_pkg::alu_add, 5'd2, 5'd1, 5'd1));
    send_bundle(ri(isa_pkg::alu_or, 5'd3, 5'd0, 12'h0a0), rr(isa_pkg::alu_sub, 5'd4, 5'd0, 5'd3));

    test_name = "same_rd";
    send_bundle(ri(isa_pkg::alu_add, 5'd5, 5'd0, 12'd3), ri(isa_pkg::alu_add, 5'd5, 5'd0, 12'd4));
    repeat (3) send_bundle(nop_word, nop_word);
    send_bundle(rr(isa_pkg::alu_add, 5'd6, 5'd5, 5'd0), ri(isa_pkg::alu_add, 5'd7, 5'd5, 12'd0));

    test_name = "x0";
    send_bundle(ri(isa_pkg::alu_add, 5'd0, 5'd1, 12'd5), rr(isa_pkg::alu_add, 5'd0, 5'd1, 5'd2));
    send_bundle(rr(isa_pkg::alu_add, 5'd8, 5'd0, 5'd0), ri(isa_pkg::alu_or, 5'd9, 5'd0, 12'h055));

    test_name = "random";
    repeat (n_random) begin
      rng = xorshift(rng);
      w0  = random_instr(rng);
      rng = xorshift(rng);
      w1  = random_instr(rng);
      send_bundle(w0, w1);
    end
    idle(4);  // Drain the pipeline through the checks

    if (u_dut.u_asserts.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: bench/dual_issue_asserts.sv
`timescale 1ns/1ns

module dual_issue_asserts (
  input logic                            clk,
  input logic                            rst,
  input logic                            issue_ready,
  input logic                            iss0_wren,
  input logic                            iss1_wren,
  input logic                            wb0_en,
  input logic [pipe_pkg::reg_addr_w-1:0] wb0_addr,
  input logic                            wb1_en,
  input logic [pipe_pkg::reg_addr_w-1:0] wb1_addr
);

  int unsigned fail_count = 0;  // Polled by the testbench

  // ====================
  // Writeback sanity
  // ====================
  a_wb0_not_x0: assert property (@(posedge clk) disable iff (rst) !(wb0_en && wb0_addr == '0))
    else begin $error("lane 0 writes back to x0"); fail_count++; end
  a_wb1_not_x0: assert property (@(posedge clk) disable iff (rst) !(wb1_en && wb1_addr == '0))
    else begin $error("lane 1 writes back to x0"); fail_count++; end

  // Reset values in the first cycle out of reset
  a_reset_vals: assert property (@(posedge clk) $fell(rst) |-> issue_ready && !wb0_en && !wb1_en)
    else begin $error("outputs not at reset values after reset"); fail_count++; end

  // A split holds the bundle for one cycle only
  a_ready_gap: assert property (@(posedge clk) disable iff (rst)
    !$past(issue_ready) |-> issue_ready)
    else begin $error("issue_ready low for two cycles"); fail_count++; end

  // ====================
  // Issue to writeback latency
  // ====================
  a_lane0_lat: assert property (@(posedge clk) disable iff (rst) wb0_en == $past(iss0_wren, 2))
    else begin $error("lane 0 writeback not two cycles after issue"); fail_count++; end
  a_lane1_lat: assert property (@(posedge clk) disable iff (rst) wb1_en == $past(iss1_wren, 2))
    else begin $error("lane 1 writeback not two cycles after issue"); fail_count++; end

endmodule

bind dual_issue_core dual_issue_asserts u_asserts (
  .clk, .rst, .issue_ready, .iss0_wren, .iss1_wren,
  .wb0_en, .wb0_addr, .wb1_en, .wb1_addr
);

// File: rtl/dual_issue_core.sv
`timescale 1ns/1ns

module dual_issue_core (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue_valid,
  input  logic [isa_pkg::xlen-1:0]        instr0,
  input  logic [isa_pkg::xlen-1:0]        instr1,
  output logic                            issue_ready,
  output logic                            wb0_en,
  output logic [pipe_pkg::reg_addr_w-1:0] wb0_addr,
  output logic [isa_pkg::xlen-1:0]        wb0_data,
  output logic                            wb1_en,
  output logic [pipe_pkg::reg_addr_w-1:0] wb1_addr,
  output logic [isa_pkg::xlen-1:0]        wb1_data
);

  reg_read_if rd0_if ();
  reg_read_if rd1_if ();

  // Issue groups
  logic                            iss0_wren;
  logic [pipe_pkg::reg_addr_w-1:0] iss0_waddr;
  logic [pipe_pkg::alu_op_w-1:0]   iss0_alu_op;
  logic                            iss0_use_imm;
  logic [isa_pkg::xlen-1:0]        iss0_imm;
  logic                            iss1_wren;
  logic [pipe_pkg::reg_addr_w-1:0] iss1_waddr;
  logic [pipe_pkg::alu_op_w-1:0]   iss1_alu_op;
  logic                            iss1_use_imm;
  logic [isa_pkg::xlen-1:0]        iss1_imm;

  // Execute stage producers
  logic                            ex0_wren;
  logic [pipe_pkg::reg_addr_w-1:0] ex0_waddr;
  logic [isa_pkg::xlen-1:0]        ex0_wdata;
  logic                            ex1_wren;
  logic [pipe_pkg::reg_addr_w-1:0] ex1_waddr;
  logic [isa_pkg::xlen-1:0]        ex1_wdata;

  logic [isa_pkg::xlen-1:0] op0_a;
  logic [isa_pkg::xlen-1:0] op0_b;
  logic [isa_pkg::xlen-1:0] op1_a;
  logic [isa_pkg::xlen-1:0] op1_b;

  // ====================
  // Front end
  // ====================
  issue_ctrl u_issue (
    .clk, .rst, .issue_valid, .instr0, .instr1, .issue_ready,
    .rd0(rd0_if.ctrl), .rd1(rd1_if.ctrl),
    .iss0_wren, .iss0_waddr, .iss0_alu_op, .iss0_use_imm, .iss0_imm,
    .iss1_wren, .iss1_waddr, .iss1_alu_op, .iss1_use_imm, .iss1_imm
  );

  reg_file u_regs (
    .clk, .rst, .rd0(rd0_if.regs), .rd1(rd1_if.regs),
    .w0_en(wb0_en), .w0_addr(wb0_addr), .w0_data(wb0_data),
    .w1_en(wb1_en), .w1_addr(wb1_addr), .w1_data(wb1_data)
  );

  forwarding u_fwd (
    .rd0(rd0_if.fwd), .rd1(rd1_if.fwd),
    .ex0_wren, .ex0_waddr, .ex0_wdata, .ex1_wren, .ex1_waddr, .ex1_wdata,
    .mem0_wren(wb0_en), .mem0_waddr(wb0_addr), .mem0_wdata(wb0_data),
    .mem1_wren(wb1_en), .mem1_waddr(wb1_addr), .mem1_wdata(wb1_data),
    .op0_a, .op0_b, .op1_a, .op1_b
  );

  // ====================
  // Lanes
  // ====================
  alu_lane u_lane0 (
    .clk, .rst, .iss_wren(iss0_wren), .iss_waddr(iss0_waddr), .iss_alu_op(iss0_alu_op),
    .iss_use_imm(iss0_use_imm), .iss_imm(iss0_imm), .op_a(op0_a), .op_b(op0_b),
    .ex_wren(ex0_wren), .ex_waddr(ex0_waddr), .ex_wdata(ex0_wdata),
    .mem_wren(wb0_en), .mem_waddr(wb0_addr), .mem_wdata(wb0_data)
  );

  alu_lane u_lane1 (
    .clk, .rst, .iss_wren(iss1_wren), .iss_waddr(iss1_waddr), .iss_alu_op(iss1_alu_op),
    .iss_use_imm(iss1_use_imm), .iss_imm(iss1_imm), .op_a(op1_a), .op_b(op1_b),
    .ex_wren(ex1_wren), .ex_waddr(ex1_waddr), .ex_wdata(ex1_wdata),
    .mem_wren(wb1_en), .mem_waddr(wb1_addr), .mem_wdata(wb1_data)
  );

endmodule

// File: rtl/alu_lane.sv
`timescale 1ns/1ns

module alu_lane (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            iss_wren,
  input  logic [pipe_pkg::reg_addr_w-1:0] iss_waddr,
  input  logic [pipe_pkg::alu_op_w-1:0]   iss_alu_op,
  input  logic                            iss_use_imm,
  input  logic [isa_pkg::xlen-1:0]        iss_imm,
  input  logic [isa_pkg::xlen-1:0]        op_a,
  input  logic [isa_pkg::xlen-1:0]        op_b,
  output logic                            ex_wren,
  output logic [pipe_pkg::reg_addr_w-1:0] ex_waddr,
  output logic [isa_pkg::xlen-1:0]        ex_wdata,
  output logic                            mem_wren,
  output logic [pipe_pkg::reg_addr_w-1:0] mem_waddr,
  output logic [isa_pkg::xlen-1:0]        mem_wdata
);

  logic [pipe_pkg::alu_op_w-1:0] ex_op;
  logic [isa_pkg::xlen-1:0]      ex_a;
  logic [isa_pkg::xlen-1:0]      ex_b;
  logic [isa_pkg::xlen-1:0]      rhs;

  // ====================
  // Execute stage
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_wren <= 1'b0;
    end else begin
      ex_wren <= iss_wren;
    end
    ex_waddr <= iss_waddr;
    ex_op    <= iss_alu_op;
    ex_a     <= op_a;
    ex_b     <= iss_use_imm ? iss_imm : op_b;  // Immediate folded in early
  end

  assign rhs = ex_b;

  always_comb begin
    case (ex_op)
      isa_pkg::alu_sub: ex_wdata = ex_a - rhs;
      isa_pkg::alu_and: ex_wdata = ex_a & rhs;
      isa_pkg::alu_or:  ex_wdata = ex_a | rhs;
      isa_pkg::alu_xor: ex_wdata = ex_a ^ rhs;
      isa_pkg::alu_slt: ex_wdata = {{(isa_pkg::xlen-1){1'b0}}, $signed(ex_a) < $signed(rhs)};
      default:          ex_wdata = ex_a + rhs;
    endcase
  end

  // Memory stage only carries the result
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wren <= 1'b0;
    end else begin
      mem_wren <= ex_wren;
    end
    mem_waddr <= ex_waddr;
    mem_wdata <= ex_wdata;
  end

endmodule

// File: rtl/forwarding.sv
`timescale 1ns/1ns

module forwarding (
  reg_read_if.fwd                         rd0,
  reg_read_if.fwd                         rd1,
  input  logic                            ex0_wren,
  input  logic [pipe_pkg::reg_addr_w-1:0] ex0_waddr,
  input  logic [isa_pkg::xlen-1:0]        ex0_wdata,
  input  logic                            ex1_wren,
  input  logic [pipe_pkg::reg_addr_w-1:0] ex1_waddr,
  input  logic [isa_pkg::xlen-1:0]        ex1_wdata,
  input  logic                            mem0_wren,
  input  logic [pipe_pkg::reg_addr_w-1:0] mem0_waddr,
  input  logic [isa_pkg::xlen-1:0]        mem0_wdata,
  input  logic                            mem1_wren,
  input  logic [pipe_pkg::reg_addr_w-1:0] mem1_waddr,
  input  logic [isa_pkg::xlen-1:0]        mem1_wdata,
  output logic [isa_pkg::xlen-1:0]        op0_a,
  output logic [isa_pkg::xlen-1:0]        op0_b,
  output logic [isa_pkg::xlen-1:0]        op1_a,
  output logic [isa_pkg::xlen-1:0]        op1_b
);

  // Later checks override earlier ones, so the youngest producer ends up on top
  function automatic logic [isa_pkg::xlen-1:0] pick(
    input logic                            rden,
    input logic [pipe_pkg::reg_addr_w-1:0] raddr,
    input logic [isa_pkg::xlen-1:0]        rdata
  );
    logic [isa_pkg::xlen-1:0] res;
    res = '0;
    if (rden) begin
      res = rdata;
      if (mem0_wren && raddr == mem0_waddr) begin
        res = mem0_wdata;
      end
      if (mem1_wren && raddr == mem1_waddr) begin
        res = mem1_wdata;
      end
      if (ex0_wren && raddr == ex0_waddr) begin
        res = ex0_wdata;
      end
      if (ex1_wren && raddr == ex1_waddr) begin
        res = ex1_wdata;  // Lane 1 beats lane 0
      end
    end
    return res;
  endfunction

  always_comb begin
    op0_a = pick(rd0.rden1, rd0.raddr1, rd0.rdata1);
    op0_b = pick(rd0.rden2, rd0.raddr2, rd0.rdata2);
    op1_a = pick(rd1.rden1, rd1.raddr1, rd1.rdata1);
    op1_b = pick(rd1.rden2, rd1.raddr2, rd1.rdata2);
  end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                            clk,
  input  logic                            rst,
  reg_read_if.regs                        rd0,
  reg_read_if.regs                        rd1,
  input  logic                            w0_en,
  input  logic [pipe_pkg::reg_addr_w-1:0] w0_addr,
  input  logic [isa_pkg::xlen-1:0]        w0_data,
  input  logic                            w1_en,
  input  logic [pipe_pkg::reg_addr_w-1:0] w1_addr,
  input  logic [isa_pkg::xlen-1:0]        w1_data
);

  logic [isa_pkg::xlen-1:0] regs [pipe_pkg::reg_count];

  // ====================
  // Write ports
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < pipe_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (w0_en) begin
        regs[w0_addr] <= w0_data;
      end
      if (w1_en) begin
        regs[w1_addr] <= w1_data;  // Younger lane wins a tie
      end
    end
  end

  // Combinational reads, x0 hardwired
  assign rd0.rdata1 = (rd0.raddr1 == '0) ? '0 : regs[rd0.raddr1];
  assign rd0.rdata2 = (rd0.raddr2 == '0) ? '0 : regs[rd0.raddr2];
  assign rd1.rdata1 = (rd1.raddr1 == '0) ? '0 : regs[rd1.raddr1];
  assign rd1.rdata2 = (rd1.raddr2 == '0) ? '0 : regs[rd1.raddr2];

endmodule

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            issue_valid,
  input  isa_pkg::instr_u                 instr0,
  input  isa_pkg::instr_u                 instr1,
  output logic                            issue_ready,
  reg_read_if.ctrl                        rd0,
  reg_read_if.ctrl                        rd1,
  output logic                            iss0_wren,
  output logic [pipe_pkg::reg_addr_w-1:0] iss0_waddr,
  output logic [pipe_pkg::alu_op_w-1:0]   iss0_alu_op,
  output logic                            iss0_use_imm,
  output logic [isa_pkg::xlen-1:0]        iss0_imm,
  output logic                            iss1_wren,
  output logic [pipe_pkg::reg_addr_w-1:0] iss1_waddr,
  output logic [pipe_pkg::alu_op_w-1:0]   iss1_alu_op,
  output logic                            iss1_use_imm,
  output logic [isa_pkg::xlen-1:0]        iss1_imm
);

  logic second_half;  // Lane 0 of the held bundle already issued
  logic split;
  logic issue0;
  logic issue1;
  logic dec0_wren;
  logic dec0_rden1;
  logic dec0_rden2;
  logic dec1_wren;
  logic dec1_rden1;
  logic dec1_rden2;

  function automatic void decode(
    input  isa_pkg::instr_u               w,
    output logic                          wren,
    output logic                          rden1,
    output logic                          rden2,
    output logic [pipe_pkg::alu_op_w-1:0] alu_op,
    output logic                          use_imm,
    output logic [isa_pkg::xlen-1:0]      imm
  );
    logic legal;
    legal   = 1'b1;
    alu_op  = isa_pkg::alu_add;
    use_imm = 1'b0;
    rden1   = 1'b0;
    rden2   = 1'b0;
    imm     = {{(isa_pkg::xlen-12){w.i.imm12[11]}}, w.i.imm12};
    case (w.r.funct3)
      isa_pkg::f3_add_sub: alu_op = isa_pkg::alu_add;
      isa_pkg::f3_slt:     alu_op = isa_pkg::alu_slt;
      isa_pkg::f3_xor:     alu_op = isa_pkg::alu_xor;
      isa_pkg::f3_or:      alu_op = isa_pkg::alu_or;
      isa_pkg::f3_and:     alu_op = isa_pkg::alu_and;
      default:             legal = 1'b0;  // Shifts and the rest are no-ops
    endcase
    if (w.r.opcode == isa_pkg::opc_op) begin
      if (w.r.funct7 == isa_pkg::f7_alt && w.r.funct3 == isa_pkg::f3_add_sub) begin
        alu_op = isa_pkg::alu_sub;
      end else if (w.r.funct7 != isa_pkg::f7_base) begin
        legal = 1'b0;
      end
      rden1 = legal;
      rden2 = legal;
    end else if (w.r.opcode == isa_pkg::opc_op_imm) begin
      use_imm = 1'b1;
      rden1   = legal;
    end else begin
      legal = 1'b0;
    end
    wren = legal && (w.r.rd != '0);  // x0 writes vanish here
  endfunction

  always_comb begin
    decode(instr0, dec0_wren, dec0_rden1, dec0_rden2, iss0_alu_op, iss0_use_imm, iss0_imm);
    decode(instr1, dec1_wren, dec1_rden1, dec1_rden2, iss1_alu_op, iss1_use_imm, iss1_imm);
  end

  // ====================
  // Same-bundle hazard
  // ====================
  assign split = issue_valid && !second_half && dec0_wren &&
                 ((dec1_rden1 && instr1.r.rs1 == instr0.r.rd) ||
                  (dec1_rden2 && instr1.r.rs2 == instr0.r.rd));

  assign issue0      = issue_valid && !second_half;
  assign issue1      = issue_valid && !split;
  assign issue_ready = !split;

  always_ff @(posedge clk) begin
    if (rst) begin
      second_half <= 1'b0;
    end else if (split) begin
      second_half <= 1'b1;
    end else if (issue_valid) begin
      second_half <= 1'b0;  // Lane 1 goes now
    end
  end

  assign iss0_wren  = issue0 && dec0_wren;
  assign iss0_waddr = instr0.r.rd;
  assign iss1_wren  = issue1 && dec1_wren;
  assign iss1_waddr = instr1.r.rd;

  assign rd0.rden1  = issue0 && dec0_rden1;
  assign rd0.rden2  = issue0 && dec0_rden2;
  assign rd0.raddr1 = instr0.r.rs1;
  assign rd0.raddr2 = instr0.r.rs2;
  assign rd1.rden1  = issue1 && dec1_rden1;
  assign rd1.rden2  = issue1 && dec1_rden2;
  assign rd1.raddr1 = instr1.r.rs1;
  assign rd1.raddr2 = instr1.r.rs2;

endmodule

// File: rtl/reg_read_if.sv
`timescale 1ns/1ns

interface reg_read_if;

  logic                           rden1;
  logic                           rden2;
  logic [pipe_pkg::reg_addr_w-1:0] raddr1;
  logic [pipe_pkg::reg_addr_w-1:0] raddr2;
  logic [isa_pkg::xlen-1:0]        rdata1;
  logic [isa_pkg::xlen-1:0]        rdata2;

  // Decoder side
  modport ctrl (output rden1, rden2, raddr1, raddr2);

  // Register file answers in the same cycle
  modport regs (input raddr1, raddr2, output rdata1, rdata2);

  modport fwd (input rden1, rden2, raddr1, raddr2, rdata1, rdata2);

endinterface

// File: rtl/pipe_pkg.sv
package pipe_pkg;

  // ====================
  // Register file geometry
  // ====================
  localparam int reg_count  = 32;
  localparam int reg_addr_w = 5;

  // Width of the ALU operation code carried down each lane
  localparam int alu_op_w = 3;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

  localparam int xlen = 32;

  // ====================
  // Opcodes and function fields
  // ====================
  localparam logic [6:0] opc_op     = 7'b0110011;  // Register-register
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // Register-immediate

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // Selects SUB

  // ALU operation codes
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_xor = 3'd4;
  localparam logic [2:0] alu_slt = 3'd5;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Same word, two views
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage
